// ==== common/riscvPkg.sv ====
`default_nettype none

package riscvPkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeFmt;

   typedef struct packed {
      logic [11:0] imm11to0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeFmt;

   typedef struct packed {
      logic [6:0] imm11to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4to0;
      logic [6:0] opcode;
   } sTypeFmt;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
   } bTypeFmt;

   typedef struct packed {
      logic [19:0] imm31to12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uTypeFmt;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jTypeFmt;

   // one word, six views
   typedef union packed {
      rTypeFmt rType;
      iTypeFmt iType;
      sTypeFmt sType;
      bTypeFmt bType;
      uTypeFmt uType;
      jTypeFmt jType;
   } instrWord;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt,
      aluSltu,
      aluSll,
      aluSrl,
      aluSra,
      aluPassB // lui
   } aluOp;

   typedef enum logic [1:0] {
      wbAlu,
      wbLoad,
      wbPc4
   } wbSel;

   typedef enum logic [1:0] {
      fwdReg,
      fwdMem,
      fwdWb
   } fwdSel;

   localparam logic [6:0] opcOp     = 7'b0110011;
   localparam logic [6:0] opcOpImm  = 7'b0010011;
   localparam logic [6:0] opcLui    = 7'b0110111;
   localparam logic [6:0] opcAuipc  = 7'b0010111;
   localparam logic [6:0] opcLoad   = 7'b0000011;
   localparam logic [6:0] opcStore  = 7'b0100011;
   localparam logic [6:0] opcBranch = 7'b1100011;
   localparam logic [6:0] opcJal    = 7'b1101111;
   localparam logic [6:0] opcJalr   = 7'b1100111;
   localparam logic [6:0] opcSystem = 7'b1110011;

endpackage

`default_nettype wire

// ==== decode/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode import riscvPkg::*; (
   input  logic [31:0] instr,
   output logic [4:0]  rs1,
   output logic [4:0]  rs2,
   output logic [4:0]  rd,
   output logic [31:0] imm,
   output aluOp        op,
   output wbSel        wb,
   output logic        aSelPc,
   output logic        bSelImm,
   output logic        regWrite,
   output logic        memRead,
   output logic        memWrite,
   output logic        isBranch,
   output logic        isJal,
   output logic        isJalr,
   output logic        isHalt,
   output logic [2:0]  funct3
);

   instrWord iw;
   logic [6:0] opcode;
   logic alt;
   logic writesRd;

   function automatic aluOp aluFromFunct(input logic [2:0] f3, input logic sel);
      case (f3)
         3'b000: return sel ? aluSub : aluAdd;
         3'b001: return aluSll;
         3'b010: return aluSlt;
         3'b011: return aluSltu;
         3'b100: return aluXor;
         3'b101: return sel ? aluSra : aluSrl;
         3'b110: return aluOr;
         default: return aluAnd;
      endcase
   endfunction

   assign iw = instr;
   assign opcode = iw.rType.opcode;
   assign rd = iw.rType.rd;
   assign funct3 = iw.rType.funct3;
   // bit 30 only means sub/sra for R-type, or for srai
   assign alt = iw.rType.funct7[5] & ((opcode == opcOp) | (funct3 == 3'b101));
   assign regWrite = writesRd & (rd != 5'd0);

   always_comb begin
      rs1 = iw.rType.rs1;
      rs2 = 5'd0; // only R, S and B read rs2
      imm = {{20{iw.iType.imm11to0[11]}}, iw.iType.imm11to0};
      op = aluAdd;
      wb = wbAlu;
      aSelPc = 1'b0;
      bSelImm = 1'b1;
      writesRd = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      isJal = 1'b0;
      isJalr = 1'b0;
      isHalt = 1'b0;
      case (opcode)
         opcOp: begin
            rs2 = iw.rType.rs2;
            bSelImm = 1'b0;
            op = aluFromFunct(funct3, alt);
            writesRd = 1'b1;
         end
         opcOpImm: begin
            op = aluFromFunct(funct3, alt);
            writesRd = 1'b1;
         end
         opcLui, opcAuipc: begin
            rs1 = 5'd0;
            imm = {iw.uType.imm31to12, 12'd0};
            op = (opcode == opcLui) ? aluPassB : aluAdd;
            aSelPc = (opcode == opcAuipc);
            writesRd = 1'b1;
         end
         opcLoad: begin
            wb = wbLoad;
            memRead = 1'b1;
            writesRd = 1'b1;
         end
         opcStore: begin
            rs2 = iw.sType.rs2;
            imm = {{20{iw.sType.imm11to5[6]}}, iw.sType.imm11to5, iw.sType.imm4to0};
            memWrite = 1'b1;
         end
         opcBranch: begin
            rs2 = iw.bType.rs2;
            imm = {{19{iw.bType.imm12}}, iw.bType.imm12, iw.bType.imm11,
                   iw.bType.imm10to5, iw.bType.imm4to1, 1'b0};
            bSelImm = 1'b0;
            isBranch = 1'b1;
         end
         opcJal: begin
            rs1 = 5'd0;
            imm = {{11{iw.jType.imm20}}, iw.jType.imm20, iw.jType.imm19to12,
                   iw.jType.imm11, iw.jType.imm10to1, 1'b0};
            wb = wbPc4;
            writesRd = 1'b1;
            isJal = 1'b1;
         end
         opcJalr: begin
            wb = wbPc4;
            writesRd = 1'b1;
            isJalr = 1'b1;
         end
         opcSystem: isHalt = (iw.iType.imm11to0 == 12'd1); // ebreak, rest is nop
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
   parameter int addrWidth = 12
) (
   input  logic                 CLK,
   input  logic                 RSTn,
   input  logic                 stall,
   input  logic                 redirect,
   input  logic [31:0]          redirectPc,
   input  logic [31:0]          iMemData,
   output logic [addrWidth-1:0] iMemAddr,
   output logic [31:0]          idInstr,
   output logic [31:0]          idPc,
   output logic                 idValid
);

   logic [31:0] pc;

   assign iMemAddr = pc[addrWidth-1:0]; // byte address

   // reset is active high here
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= 32'd0;
         idValid <= 1'b0;
      end else if (redirect) begin
         pc <= redirectPc;
         idValid <= 1'b0; // squash the word in flight
      end else if (!stall) begin
         pc <= pc + 32'd4;
         idValid <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall && !redirect) begin
         idInstr <= iMemData;
         idPc <= pc;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import riscvPkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  aluOp        op,
   input  logic [31:0] cmpA,
   input  logic [31:0] cmpB,
   input  logic [2:0]  funct3,
   output logic [31:0] result,
   output logic        branchTaken
);

   always_comb begin
      case (op)
         aluAdd:   result = a + b;
         aluSub:   result = a - b;
         aluAnd:   result = a & b;
         aluOr:    result = a | b;
         aluXor:   result = a ^ b;
         aluSlt:   result = {31'd0, $signed(a) < $signed(b)};
         aluSltu:  result = {31'd0, a < b};
         aluSll:   result = a << b[4:0];
         aluSrl:   result = a >> b[4:0];
         aluSra:   result = $unsigned($signed(a) >>> b[4:0]);
         aluPassB: result = b;
         default:  result = a + b;
      endcase
   end

   // comparator works on the forwarded rs1/rs2, not on the ALU inputs
   always_comb begin
      case (funct3)
         3'b000:  branchTaken = (cmpA == cmpB);
         3'b001:  branchTaken = (cmpA != cmpB);
         3'b100:  branchTaken = ($signed(cmpA) < $signed(cmpB));
         3'b101:  branchTaken = ($signed(cmpA) >= $signed(cmpB));
         3'b110:  branchTaken = (cmpA < cmpB);
         3'b111:  branchTaken = (cmpA >= cmpB);
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/forwardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forwardUnit import riscvPkg::*; (
   input  logic [4:0] exRs1,
   input  logic [4:0] exRs2,
   input  logic [4:0] memRd,
   input  logic [4:0] wbRd,
   input  logic       memRegWrite,
   input  logic       wbRegWrite,
   input  logic [4:0] exRd,
   input  logic       exMemRead,
   input  logic [4:0] idRs1,
   input  logic [4:0] idRs2,
   output fwdSel      fwdA,
   output fwdSel      fwdB,
   output logic       idBypass1,
   output logic       idBypass2,
   output logic       loadStall
);

   logic memLive;
   logic wbLive;
   logic loadLive;

   // x0 never forwards
   assign memLive = memRegWrite && (memRd != 5'd0);
   assign wbLive = wbRegWrite && (wbRd != 5'd0);
   assign loadLive = exMemRead && (exRd != 5'd0);

   // younger result wins
   assign fwdA = (memLive && memRd == exRs1) ? fwdMem :
                 (wbLive && wbRd == exRs1) ? fwdWb : fwdReg;
   assign fwdB = (memLive && memRd == exRs2) ? fwdMem :
                 (wbLive && wbRd == exRs2) ? fwdWb : fwdReg;

   assign idBypass1 = wbLive && (wbRd == idRs1); // rf write lands at the same edge
   assign idBypass2 = wbLive && (wbRd == idRs2);

   assign loadStall = loadLive && ((exRd == idRs1) || (exRd == idRs2));

endmodule

`default_nettype wire

// ==== verilog/riscvTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTop import riscvPkg::*; #(
   parameter int addrWidth = 12
) (
   input  logic                 CLK,
   input  logic                 RSTn,
   output logic [addrWidth-1:0] iMemAddr,
   input  logic [31:0]          iMemData,
   output logic [addrWidth-1:0] dMemAddr,
   output logic [31:0]          dMemWdata,
   output logic                 dMemWen,
   input  logic [31:0]          dMemRdata,
   output logic [4:0]           rfRa1,
   output logic [4:0]           rfRa2,
   input  logic [31:0]          rfRd1,
   input  logic [31:0]          rfRd2,
   output logic                 rfWe,
   output logic [4:0]           rfWa,
   output logic [31:0]          rfWd,
   output logic                 halt,
   output logic [31:0]          numInst,
   output logic [31:0]          outputPort
);

   logic [31:0] idInstr, idPc, idRs1Val, idRs2Val, decImm;
   logic [4:0] decRs1, decRs2, decRd;
   logic [2:0] decFunct3;
   aluOp decOp;
   wbSel decWbSel;
   logic idValid, decASelPc, decBSelImm, decRegWrite, decMemRead, decMemWrite;
   logic decIsBranch, decIsJal, decIsJalr, decIsHalt;
   logic idBypass1, idBypass2, loadStall, redirect, haltPend;
   logic [31:0] redirectPc;

   logic exValid, exASelPc, exBSelImm, exRegWrite, exMemRead, exMemWrite;
   logic exIsBranch, exIsJal, exIsJalr, exIsHalt, branchTaken;
   logic [31:0] exPc, exImm, exRs1Val, exRs2Val, opA, opB, aluResult, exResult;
   logic [4:0] exRs1, exRs2, exRd;
   logic [2:0] exFunct3;
   aluOp exOp;
   wbSel exWbSel;
   fwdSel fwdA, fwdB;

   logic memValid, memRegWrite, memMemWrite, memIsBranch, memIsHalt;
   logic [31:0] memAlu, memRs2Val, memWordAddr;
   logic [4:0] memRd;
   wbSel memWbSel;

   logic wbValid, wbRegWrite, wbMemWrite, wbIsBranch, wbIsHalt;
   logic [31:0] wbAlu, wbLoadData;
   logic [4:0] wbRd;
   wbSel wbWbSel;

   fetchStage #(.addrWidth(addrWidth)) fetch_i (
      .CLK(CLK), .RSTn(RSTn), .stall(loadStall | haltPend), .redirect(redirect),
      .redirectPc(redirectPc), .iMemData(iMemData), .iMemAddr(iMemAddr),
      .idInstr(idInstr), .idPc(idPc), .idValid(idValid)
   );

   instrDecode decode_i (
      .instr(idInstr), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
      .op(decOp), .wb(decWbSel), .aSelPc(decASelPc), .bSelImm(decBSelImm),
      .regWrite(decRegWrite), .memRead(decMemRead), .memWrite(decMemWrite),
      .isBranch(decIsBranch), .isJal(decIsJal), .isJalr(decIsJalr),
      .isHalt(decIsHalt), .funct3(decFunct3)
   );

   // exMemRead only matters when ID holds a live instruction
   forwardUnit forward_i (
      .exRs1(exRs1), .exRs2(exRs2), .memRd(memRd), .wbRd(wbRd),
      .memRegWrite(memValid & memRegWrite), .wbRegWrite(rfWe), .exRd(exRd),
      .exMemRead(exValid & exMemRead & idValid), .idRs1(decRs1), .idRs2(decRs2),
      .fwdA(fwdA), .fwdB(fwdB), .idBypass1(idBypass1), .idBypass2(idBypass2),
      .loadStall(loadStall)
   );

   assign rfRa1 = decRs1;
   assign rfRa2 = decRs2;
   assign idRs1Val = idBypass1 ? rfWd : rfRd1;
   assign idRs2Val = idBypass2 ? rfWd : rfRd2;

   // ID/EX, bubble on stall, redirect or empty ID
   always_ff @(posedge CLK) begin
      if (RSTn) exValid <= 1'b0;
      else exValid <= idValid & ~loadStall & ~redirect;
   end

   always_ff @(posedge CLK) begin
      exPc <= idPc;
      exImm <= decImm;
      exRs1Val <= idRs1Val;
      exRs2Val <= idRs2Val;
      exRs1 <= decRs1;
      exRs2 <= decRs2;
      exRd <= decRd;
      exFunct3 <= decFunct3;
      exOp <= decOp;
      exWbSel <= decWbSel;
      exASelPc <= decASelPc;
      exBSelImm <= decBSelImm;
      exRegWrite <= decRegWrite;
      exMemRead <= decMemRead;
      exMemWrite <= decMemWrite;
      exIsBranch <= decIsBranch;
      exIsJal <= decIsJal;
      exIsJalr <= decIsJalr;
      exIsHalt <= decIsHalt;
   end

   assign opA = (fwdA == fwdMem) ? memAlu : (fwdA == fwdWb) ? rfWd : exRs1Val;
   assign opB = (fwdB == fwdMem) ? memAlu : (fwdB == fwdWb) ? rfWd : exRs2Val;

   aluUnit alu_i (
      .a(exASelPc ? exPc : opA), .b(exBSelImm ? exImm : opB), .op(exOp),
      .cmpA(opA), .cmpB(opB), .funct3(exFunct3), .result(aluResult),
      .branchTaken(branchTaken)
   );

   // branches carry the taken flag down for outputPort
   assign exResult = exIsBranch ? {31'd0, branchTaken} :
                     (exWbSel == wbPc4) ? exPc + 32'd4 : aluResult;

   // ebreak also flushes the two younger slots
   assign redirect = exValid & ((exIsBranch & branchTaken) | exIsJal | exIsJalr | exIsHalt);

   always_comb begin
      if (exIsJalr) redirectPc = (opA + exImm) & 32'hFFFF_FFFE;
      else if (exIsHalt) redirectPc = exPc; // park, fetch freezes next
      else redirectPc = exPc + exImm;
   end

   // EX/MEM
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         memValid <= 1'b0;
         haltPend <= 1'b0;
      end else begin
         memValid <= exValid;
         if (exValid & exIsHalt) haltPend <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      memAlu <= exResult;
      memRs2Val <= opB;
      memRd <= exRd;
      memRegWrite <= exRegWrite;
      memMemWrite <= exMemWrite;
      memWbSel <= exWbSel;
      memIsBranch <= exIsBranch;
      memIsHalt <= exIsHalt;
   end

   assign memWordAddr = memAlu >> 2;
   assign dMemAddr = memWordAddr[addrWidth-1:0];
   assign dMemWdata = memRs2Val;
   assign dMemWen = ~(memValid & memMemWrite); // active low

   // MEM/WB
   always_ff @(posedge CLK) begin
      if (RSTn) wbValid <= 1'b0;
      else wbValid <= memValid;
   end

   always_ff @(posedge CLK) begin
      wbAlu <= memAlu;
      wbLoadData <= dMemRdata;
      wbRd <= memRd;
      wbRegWrite <= memRegWrite;
      wbMemWrite <= memMemWrite;
      wbWbSel <= memWbSel;
      wbIsBranch <= memIsBranch;
      wbIsHalt <= memIsHalt;
   end

   assign rfWe = wbValid & wbRegWrite;
   assign rfWa = wbRd;
   assign rfWd = (wbWbSel == wbLoad) ? wbLoadData : wbAlu;
   assign outputPort = wbIsHalt ? 32'd0 : (wbMemWrite | wbIsBranch) ? wbAlu : rfWd;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         numInst <= 32'd0;
         halt <= 1'b0;
      end else begin
         if (wbValid) numInst <= numInst + 32'd1;
         if (wbValid & wbIsHalt) halt <= 1'b1; // sticky
      end
   end

endmodule

`default_nettype wire

// ==== test/riscvTop_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTopSva (
   input logic        CLK,
   input logic        RSTn,
   input logic        dMemWen,
   input logic        rfWe,
   input logic        halt,
   input logic [31:0] numInst
);

   // one reset edge is enough to clear both strobes
   resetQuiet: assert property (@(posedge CLK) RSTn && $past(RSTn) |-> dMemWen && !rfWe)
      else $error("write strobe active during reset");

   countFrozen: assert property (@(posedge CLK) disable iff (RSTn) halt |=> $stable(numInst))
      else $error("numInst moved after halt");

   noWriteHalted: assert property (@(posedge CLK) disable iff (RSTn) halt |-> !rfWe)
      else $error("register write while halted");

endmodule

bind riscvTop riscvTopSva riscvTopSva_i (
   .CLK(CLK),
   .RSTn(RSTn),
   .dMemWen(dMemWen),
   .rfWe(rfWe),
   .halt(halt),
   .numInst(numInst)
);

`default_nettype wire

// ==== test/riscvTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvTopTb import riscvPkg::*; ();

   localparam int addrW = 12;
   localparam int numProgs = 30;
   localparam int progLen = 48; // ebreak included
   localparam int imemWords = 1 << (addrW - 2);
   localparam int dmemWords = 1 << addrW;
   localparam longint budgetNs = longint'(numProgs) * (progLen * 40 + 20) * 8;
   localparam logic [31:0] nopWord = 32'h0000_0013;

   logic CLK;
   logic RSTn;
   logic [addrW-1:0] iMemAddr;
   logic [addrW-1:0] dMemAddr;
   logic [31:0] iMemData, dMemWdata, dMemRdata, rfRd1, rfRd2, rfWd, numInst, outputPort;
   logic [4:0] rfRa1, rfRa2, rfWa;
   logic dMemWen, rfWe, halt;

   logic [31:0] imem [imemWords];
   logic [31:0] dmem [dmemWords];
   logic [31:0] dmemInit [dmemWords];
   logic [31:0] rf [32];
   logic [31:0] rfInit [32];
   logic [31:0] mRf [32];
   logic [31:0] mMem [dmemWords];
   logic [31:0] expWa[$], expWd[$], expStA[$], expStD[$];
   int kindOf [progLen];
   int modelCount;
   logic stPend = 1'b0; // store reaches WB next cycle
   logic [31:0] stByte;

   riscvTop #(.addrWidth(addrW)) riscvTop_i (
      .CLK(CLK), .RSTn(RSTn), .iMemAddr(iMemAddr), .iMemData(iMemData),
      .dMemAddr(dMemAddr), .dMemWdata(dMemWdata), .dMemWen(dMemWen), .dMemRdata(dMemRdata),
      .rfRa1(rfRa1), .rfRa2(rfRa2), .rfRd1(rfRd1), .rfRd2(rfRd2), .rfWe(rfWe), .rfWa(rfWa),
      .rfWd(rfWd), .halt(halt), .numInst(numInst), .outputPort(outputPort)
   );

   assign iMemData = imem[iMemAddr[addrW-1:2]];
   assign dMemRdata = dmem[dMemAddr];
   assign rfRd1 = rf[rfRa1];
   assign rfRd2 = rf[rfRa2];

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   // memories reload their start image while reset is held
   always @(posedge CLK) begin
      if (RSTn === 1'b1) begin
         for (int k = 0; k < 32; k++) rf[k] <= rfInit[k];
         for (int k = 0; k < dmemWords; k++) dmem[k] <= dmemInit[k];
      end else begin
         if (rfWe === 1'b1) rf[rfWa] <= rfWd;
         if (dMemWen === 1'b0) dmem[dMemAddr] <= dMemWdata;
      end
   end

   task automatic stopRun(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         stopRun($sformatf("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp));
   endtask

   function automatic logic [4:0] pickReg();
      return 5'($urandom % 7 + 1); // x1..x7 only
   endfunction

   // forward target that never lands on a jalr
   function automatic int fwdTarget(input int i);
      int j;
      j = i + 1 + int'($urandom % 3);
      if (j > progLen - 1) j = progLen - 1;
      if (kindOf[j] == 10) j = j + 1;
      return j;
   endfunction

   task automatic genProgram();
      instrWord w;
      logic [2:0] f3;
      logic [6:0] f7;
      logic [11:0] imm;
      logic [12:0] off13;
      logic [20:0] off21;
      logic [4:0] baseReg;
      int i;
      int r;
      i = 0;
      while (i < progLen - 1) begin
         r = int'($urandom % 20);
         if (r >= 18 && i < progLen - 2) begin
            kindOf[i] = 9; // auipc base for the jalr after it
            kindOf[i + 1] = 10;
            i = i + 2;
         end else begin
            kindOf[i] = (r < 6) ? 0 : (r < 10) ? 1 : (r < 12) ? r - 8 : (r < 14) ? 4 :
                        (r == 14) ? 5 : (r < 17) ? 6 : (r == 17) ? 7 : 1;
            i = i + 1;
         end
      end
      kindOf[progLen - 1] = 11;
      baseReg = 5'd1;
      for (int k = 0; k < progLen; k++) begin
         f3 = 3'($urandom % 8);
         case (kindOf[k])
            0: begin
               f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
               w.rType = '{f7, pickReg(), pickReg(), f3, pickReg(), opcOp};
            end
            1: begin
               imm = 12'($urandom);
               if (f3 == 3'd1) imm[11:5] = 7'h00;
               if (f3 == 3'd5) imm[11:5] = ($urandom % 2 == 0) ? 7'h00 : 7'h20;
               w.iType = '{imm, pickReg(), f3, pickReg(), opcOpImm};
            end
            2: w.uType = '{20'($urandom), pickReg(), opcLui};
            3: w.uType = '{20'($urandom), pickReg(), opcAuipc};
            4: w.iType = '{12'h400 + 12'(4 * ($urandom % 64)), 5'd0, 3'b010, pickReg(), opcLoad};
            5: begin
               imm = 12'h400 + 12'(4 * ($urandom % 64));
               w.sType = '{imm[11:5], pickReg(), 5'd0, 3'b010, imm[4:0], opcStore};
            end
            6: begin
               f3 = 3'($urandom % 6);
               if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip the two unused encodings
               off13 = 13'((fwdTarget(k) - k) * 4);
               w.bType = '{off13[12], off13[10:5], pickReg(), pickReg(), f3, off13[4:1],
                           off13[11], opcBranch};
            end
            7: begin
               off21 = 21'((fwdTarget(k) - k) * 4);
               w.jType = '{off21[20], off21[10:1], off21[11], off21[19:12], pickReg(), opcJal};
            end
            9: begin
               baseReg = pickReg();
               w.uType = '{20'd0, baseReg, opcAuipc};
            end
            10: w.iType = '{12'((fwdTarget(k) - k + 1) * 4), baseReg, 3'b000, pickReg(), opcJalr};
            default: w = 32'h0010_0073; // ebreak
         endcase
         imem[k] = w;
      end
   endtask

   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            else return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         3'd7: return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // sequential ISA model, fills the expected write and store streams
   task automatic runModel();
      logic [31:0] instr, pc, a, b, immI, res, nextPc, addr;
      logic done;
      logic wr;
      for (int k = 0; k < 32; k++) mRf[k] = rfInit[k];
      for (int k = 0; k < dmemWords; k++) mMem[k] = dmemInit[k];
      pc = 32'd0;
      done = 1'b0;
      modelCount = 0;
      while (!done && modelCount < progLen) begin
         instr = imem[pc[addrW-1:2]];
         a = mRf[instr[19:15]];
         b = mRf[instr[24:20]];
         immI = {{20{instr[31]}}, instr[31:20]};
         nextPc = pc + 32'd4;
         wr = 1'b1;
         res = 32'd0;
         modelCount = modelCount + 1;
         case (instr[6:0])
            opcOp: res = aluRef(instr[14:12], instr[30], a, b);
            opcOpImm: res = aluRef(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, immI);
            opcLui: res = {instr[31:12], 12'd0};
            opcAuipc: res = pc + {instr[31:12], 12'd0};
            opcLoad: begin
               addr = a + immI;
               res = mMem[addr[addrW+1:2]];
            end
            opcStore: begin
               wr = 1'b0;
               addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
               mMem[addr[addrW+1:2]] = b;
               expStA.push_back(32'(addr[addrW+1:2]));
               expStD.push_back(b);
            end
            opcBranch: begin
               wr = 1'b0;
               if (branchRef(instr[14:12], a, b))
                  nextPc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            end
            opcJal: begin
               res = pc + 32'd4;
               nextPc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            end
            opcJalr: begin
               res = pc + 32'd4;
               nextPc = (a + immI) & 32'hFFFF_FFFE;
            end
            default: begin
               wr = 1'b0;
               done = 1'b1;
            end
         endcase
         if (wr && instr[11:7] != 5'd0) begin
            mRf[instr[11:7]] = res;
            expWa.push_back(32'(instr[11:7]));
            expWd.push_back(res);
         end
         pc = nextPc;
      end
   endtask

   always @(negedge CLK) begin : monitor
      logic [31:0] wd;
      logic [31:0] sa;
      if (stPend) begin
         checkEq("outputPort store", outputPort, stByte);
         stPend = 1'b0;
      end
      if (RSTn === 1'b0 && rfWe === 1'b1) begin
         if (expWd.size() == 0) begin
            stopRun("register write seen that the ISA model never made");
         end else begin
            wd = expWd.pop_front();
            checkEq("rfWa", 32'(rfWa), expWa.pop_front());
            checkEq("rfWd", rfWd, wd);
            checkEq("outputPort", outputPort, wd);
         end
      end
      if (RSTn === 1'b0 && dMemWen === 1'b0) begin
         if (expStA.size() == 0) begin
            stopRun("store seen that the ISA model never made");
         end else begin
            sa = expStA.pop_front();
            checkEq("dMemAddr", 32'(dMemAddr), sa);
            checkEq("dMemWdata", dMemWdata, expStD.pop_front());
            stByte = sa << 2; // byte address shows in WB
            stPend = 1'b1;
         end
      end
   end

   initial begin
      #(budgetNs);
      stopRun("timeout: the core did not halt within the cycle budget");
   end

   initial begin
      RSTn = 1'b1;
      void'($urandom(84));
      for (int k = 0; k < imemWords; k++) imem[k] = nopWord;
      for (int p = 0; p < numProgs; p++) begin
         @(posedge CLK);
         #1 RSTn = 1'b1;
         genProgram();
         for (int k = 0; k < 32; k++) rfInit[k] = (k >= 1 && k <= 7) ? $urandom : 32'd0;
         for (int k = 0; k < dmemWords; k++) dmemInit[k] = $urandom;
         runModel();
         repeat (10) @(posedge CLK);
         #1 RSTn = 1'b0;
         while (halt !== 1'b1) @(posedge CLK);
         repeat (6) @(posedge CLK); // room for any stray write
         checkEq("numInst", numInst, 32'(modelCount));
         checkEq("writes left", 32'(expWd.size()), 32'd0);
         checkEq("stores left", 32'(expStA.size()), 32'd0);
         for (int k = 1; k < 32; k++) checkEq($sformatf("x%0d", k), rf[k], mRf[k]);
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== riscvTop.f ====
common/riscvPkg.sv
decode/instrDecode.sv
verilog/fetchStage.sv
verilog/aluUnit.sv
verilog/forwardUnit.sv
verilog/riscvTop.sv
test/riscvTop_sva.sv
test/riscvTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the riscvTop testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module riscvTopTb -f riscvTop.f -o simv

# tee keeps the log even when the simulation stops on an error
./obj_dir/simv | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
